//--- common/core_pkg.sv
package core_pkg;

    localparam int xlen = 64;

    typedef logic [31:0]     instr_t;
    typedef logic [4:0]      reg_addr_t;
    typedef logic [xlen-1:0] word_t;

    // Major opcodes of the supported RV64I subset
    typedef enum logic [6:0] {
        op_reg    = 7'b0110011,
        op_imm    = 7'b0010011,
        op_load   = 7'b0000011,
        op_store  = 7'b0100011,
        op_branch = 7'b1100011
    } opcode_e;

    // alu_add must stay zero so that a zero ctrl_t is a clean bubble
    typedef enum logic [3:0] {
        alu_add  = 4'd0,
        alu_sub  = 4'd1,
        alu_and  = 4'd2,
        alu_or   = 4'd3,
        alu_xor  = 4'd4,
        alu_slt  = 4'd5,
        alu_sltu = 4'd6,
        alu_sll  = 4'd7,
        alu_srl  = 4'd8,
        alu_sra  = 4'd9
    } alu_op_e;

    // funct3 values shared by several opcodes
    localparam logic [2:0] f3_add_sub = 3'b000;
    localparam logic [2:0] f3_beq     = 3'b000;
    localparam logic [2:0] f3_double  = 3'b011;
    localparam logic [2:0] f3_shift_r = 3'b101;

    localparam logic [6:0] funct7_base = 7'b0000000;
    localparam logic [6:0] funct7_alt  = 7'b0100000;

    typedef struct packed {
        logic    reg_write;
        logic    mem_read;
        logic    mem_write;
        logic    branch;
        logic    alu_src;
        alu_op_e alu_op;
    } ctrl_t;

endpackage

//--- common/pipe_ifs.sv
`timescale 1ns/1ps

// Writeback bus from the memory/writeback register
interface wb_if import core_pkg::*; ();

    logic      valid;
    reg_addr_t rd;
    word_t     data;
    logic      write;

    modport source (
        output valid, rd, data, write
    );

    modport sink (
        input valid, rd, data, write
    );

endinterface

// Pipeline control between fetch, decode and execute
interface hazard_if import core_pkg::*; ();

    logic      stall;
    logic      flush;
    word_t     redirect;
    reg_addr_t load_rd;

    modport fetch (
        input stall, flush, redirect
    );

    modport decode (
        output stall, load_rd,
        input  flush
    );

    modport execute (
        output flush, redirect
    );

endinterface

//--- filelist.f
common/core_pkg.sv
common/pipe_ifs.sv
logic/fetch_stage.sv
logic/register_file.sv
logic/decode_stage.sv
logic/execute_stage.sv
logic/memory_stage.sv
logic/rv_core.sv
tb/core_checker.sv
tb/tb_rv_core.sv

//--- logic/decode_stage.sv
`timescale 1ns/1ps

module decode_stage import core_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  instr_t    fd_instr,
    input  word_t     fd_pc,
    wb_if.sink        wb,
    hazard_if.decode  hz,
    output ctrl_t     de_ctrl,
    output word_t     de_pc,
    output word_t     de_rs1_data,
    output word_t     de_rs2_data,
    output word_t     de_imm,
    output reg_addr_t de_rs1,
    output reg_addr_t de_rs2,
    output reg_addr_t de_rd
);

    opcode_e    opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    reg_addr_t  rs1;
    reg_addr_t  rs2;
    reg_addr_t  rd;
    ctrl_t      ctrl;
    logic       uses_rs2;
    word_t      imm;
    word_t      rs1_data;
    word_t      rs2_data;

    assign opcode = opcode_e'(fd_instr[6:0]);
    assign rd     = fd_instr[11:7];
    assign funct3 = fd_instr[14:12];
    assign rs1    = fd_instr[19:15];
    assign rs2    = fd_instr[24:20];
    assign funct7 = fd_instr[31:25];

    register_file regs0 (
        .clk      (clk),
        .rst_n    (rst_n),
        .rs1      (rs1),
        .rs2      (rs2),
        .wb       (wb),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data)
    );

    // Anything outside the subset stays a bubble
    always_comb begin
        ctrl     = '0;
        uses_rs2 = 1'b0;
        case (opcode)
            op_reg: begin
                uses_rs2 = 1'b1;
                if ((funct7 == funct7_base) || ((funct7 == funct7_alt) &&
                    ((funct3 == f3_add_sub) || (funct3 == f3_shift_r)))) begin
                    ctrl.reg_write = 1'b1;
                    case (funct3)
                        3'b000: ctrl.alu_op = funct7[5] ? alu_sub : alu_add;
                        3'b001: ctrl.alu_op = alu_sll;
                        3'b010: ctrl.alu_op = alu_slt;
                        3'b011: ctrl.alu_op = alu_sltu;
                        3'b100: ctrl.alu_op = alu_xor;
                        3'b101: ctrl.alu_op = funct7[5] ? alu_sra : alu_srl;
                        3'b110: ctrl.alu_op = alu_or;
                        default: ctrl.alu_op = alu_and;
                    endcase
                end
            end
            op_imm: begin
                if (funct3 == f3_add_sub) begin
                    ctrl.reg_write = 1'b1;
                    ctrl.alu_src   = 1'b1;
                end
            end
            op_load: begin
                if (funct3 == f3_double) begin
                    ctrl.reg_write = 1'b1;
                    ctrl.mem_read  = 1'b1;
                    ctrl.alu_src   = 1'b1;
                end
            end
            op_store: begin
                uses_rs2 = 1'b1;
                if (funct3 == f3_double) begin
                    ctrl.mem_write = 1'b1;
                    ctrl.alu_src   = 1'b1;
                end
            end
            op_branch: begin
                uses_rs2 = 1'b1;
                if (funct3 == f3_beq) begin
                    ctrl.branch = 1'b1;
                    ctrl.alu_op = alu_sub;
                end
            end
            default: ;
        endcase
    end

    // I, S and B formats
    always_comb begin
        case (opcode)
            op_store:  imm = {{52{fd_instr[31]}}, fd_instr[31:25], fd_instr[11:7]};
            op_branch: imm = {{51{fd_instr[31]}}, fd_instr[31], fd_instr[7],
                              fd_instr[30:25], fd_instr[11:8], 1'b0};
            default:   imm = {{52{fd_instr[31]}}, fd_instr[31:20]};
        endcase
    end

    // Load-use check against the load sitting in execute
    assign hz.load_rd = de_ctrl.mem_read ? de_rd : '0;
    assign hz.stall   = (hz.load_rd != '0) &&
                        ((hz.load_rd == rs1) || (uses_rs2 && (hz.load_rd == rs2)));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            de_ctrl <= '0;
        end else if (hz.flush || hz.stall) begin
            de_ctrl <= '0;
        end else begin
            de_ctrl <= ctrl;
        end
    end

    always_ff @(posedge clk) begin
        de_pc       <= fd_pc;
        de_rs1_data <= rs1_data;
        de_rs2_data <= rs2_data;
        de_imm      <= imm;
        de_rs1      <= rs1;
        de_rs2      <= rs2;
        de_rd       <= rd;
    end

endmodule

//--- logic/execute_stage.sv
`timescale 1ns/1ps

module execute_stage import core_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  ctrl_t     de_ctrl,
    input  word_t     de_pc,
    input  word_t     de_rs1_data,
    input  word_t     de_rs2_data,
    input  word_t     de_imm,
    input  reg_addr_t de_rs1,
    input  reg_addr_t de_rs2,
    input  reg_addr_t de_rd,
    wb_if.sink        wb,
    hazard_if.execute hz,
    output ctrl_t     em_ctrl,
    output word_t     em_result,
    output word_t     em_store_data,
    output reg_addr_t em_rd
);

    word_t      fwd_a;
    word_t      fwd_b;
    word_t      op_b;
    word_t      alu_result;
    logic [5:0] shamt;

    // Execute/memory result first, then writeback
    function automatic word_t forward(reg_addr_t src, word_t reg_val);
        if (em_ctrl.reg_write && (em_rd != '0) && (em_rd == src)) begin
            return em_result;
        end else if (wb.write && (wb.rd != '0) && (wb.rd == src)) begin
            return wb.data;
        end
        return reg_val;
    endfunction

    always_comb begin
        fwd_a = forward(de_rs1, de_rs1_data);
        fwd_b = forward(de_rs2, de_rs2_data);
    end

    assign op_b  = de_ctrl.alu_src ? de_imm : fwd_b;
    assign shamt = op_b[5:0];

    always_comb begin
        case (de_ctrl.alu_op)
            alu_add:  alu_result = fwd_a + op_b;
            alu_sub:  alu_result = fwd_a - op_b;
            alu_and:  alu_result = fwd_a & op_b;
            alu_or:   alu_result = fwd_a | op_b;
            alu_xor:  alu_result = fwd_a ^ op_b;
            alu_slt:  alu_result = word_t'($signed(fwd_a) < $signed(op_b));
            alu_sltu: alu_result = word_t'(fwd_a < op_b);
            alu_sll:  alu_result = fwd_a << shamt;
            alu_srl:  alu_result = fwd_a >> shamt;
            alu_sra:  alu_result = word_t'($signed(fwd_a) >>> shamt);
            default:  alu_result = '0;
        endcase
    end

    // BEQ taken kills the two younger instructions
    assign hz.flush    = de_ctrl.branch && (fwd_a == fwd_b);
    assign hz.redirect = de_pc + de_imm;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            em_ctrl <= '0;
        end else begin
            em_ctrl <= de_ctrl;
        end
    end

    always_ff @(posedge clk) begin
        em_result     <= alu_result;
        em_store_data <= fwd_b;
        em_rd         <= de_rd;
    end

endmodule

//--- logic/fetch_stage.sv
`timescale 1ns/1ps

module fetch_stage import core_pkg::*; #(
    parameter word_t reset_pc = '0
) (
    input  logic   clk,
    input  logic   rst_n,
    input  instr_t instruction_in,
    output word_t  pc_out,
    output instr_t fd_instr,
    output word_t  fd_pc,
    hazard_if.fetch hz
);

    word_t pc;

    assign pc_out = pc;

    // An all-zero word decodes as a bubble
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc       <= reset_pc;
            fd_instr <= '0;
            fd_pc    <= '0;
        end else if (hz.flush) begin
            pc       <= hz.redirect;
            fd_instr <= '0;
            fd_pc    <= '0;
        end else if (!hz.stall) begin
            pc       <= pc + word_t'(4);
            fd_instr <= instruction_in;
            fd_pc    <= pc;
        end
    end

endmodule

//--- logic/memory_stage.sv
`timescale 1ns/1ps

module memory_stage import core_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  ctrl_t     em_ctrl,
    input  word_t     em_result,
    input  word_t     em_store_data,
    input  reg_addr_t em_rd,
    input  word_t     mem_read_data,
    output logic      mem_request,
    output logic      mem_write,
    output word_t     mem_addr,
    output word_t     mem_data,
    output logic      align_fault,
    wb_if.source      wb
);

    logic  access;
    logic  write_next;
    word_t result;

    // Doubleword accesses only
    assign access      = em_ctrl.mem_read || em_ctrl.mem_write;
    assign align_fault = access && (em_result[2:0] != 3'b000);

    assign mem_request = access && !align_fault;
    assign mem_write   = em_ctrl.mem_write && !align_fault;
    assign mem_addr    = em_result;
    assign mem_data    = em_store_data;

    // A faulting load never reaches the register file
    assign write_next = em_ctrl.reg_write && !align_fault;
    assign result     = em_ctrl.mem_read ? mem_read_data : em_result;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wb.write <= 1'b0;
            wb.valid <= 1'b0;
        end else begin
            wb.write <= write_next;
            wb.valid <= write_next && (em_rd != '0);
        end
    end

    always_ff @(posedge clk) begin
        wb.rd   <= em_rd;
        wb.data <= result;
    end

endmodule

//--- logic/register_file.sv
`timescale 1ns/1ps

module register_file import core_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  reg_addr_t rs1,
    input  reg_addr_t rs2,
    wb_if.sink        wb,
    output word_t     rs1_data,
    output word_t     rs2_data
);

    word_t regs [32];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wb.write && (wb.rd != '0)) begin
            regs[wb.rd] <= wb.data;
        end
    end

    // Same-cycle writeback is visible to decode
    assign rs1_data = (rs1 == '0) ? '0 :
                      (wb.write && (wb.rd == rs1)) ? wb.data : regs[rs1];
    assign rs2_data = (rs2 == '0) ? '0 :
                      (wb.write && (wb.rd == rs2)) ? wb.data : regs[rs2];

endmodule

//--- logic/rv_core.sv
`timescale 1ns/1ps

module rv_core import core_pkg::*; #(
    parameter word_t reset_pc = '0
) (
    input  logic      clk,
    input  logic      rst_n,
    input  instr_t    instruction_in,
    input  word_t     mem_read_data,
    output word_t     pc_out,
    output word_t     mem_addr,
    output word_t     mem_data,
    output logic      mem_request,
    output logic      mem_write,
    output logic      align_fault,
    output logic      retire_valid,
    output reg_addr_t retire_rd,
    output word_t     retire_data
);

    instr_t    fd_instr;
    word_t     fd_pc;
    ctrl_t     de_ctrl;
    word_t     de_pc;
    word_t     de_rs1_data;
    word_t     de_rs2_data;
    word_t     de_imm;
    reg_addr_t de_rs1;
    reg_addr_t de_rs2;
    reg_addr_t de_rd;
    ctrl_t     em_ctrl;
    word_t     em_result;
    word_t     em_store_data;
    reg_addr_t em_rd;

    wb_if     wb0 ();
    hazard_if hz0 ();

    fetch_stage #(
        .reset_pc (reset_pc)
    ) fetch0 (
        .clk            (clk),
        .rst_n          (rst_n),
        .instruction_in (instruction_in),
        .pc_out         (pc_out),
        .fd_instr       (fd_instr),
        .fd_pc          (fd_pc),
        .hz             (hz0)
    );

    decode_stage decode0 (
        .clk         (clk),
        .rst_n       (rst_n),
        .fd_instr    (fd_instr),
        .fd_pc       (fd_pc),
        .wb          (wb0),
        .hz          (hz0),
        .de_ctrl     (de_ctrl),
        .de_pc       (de_pc),
        .de_rs1_data (de_rs1_data),
        .de_rs2_data (de_rs2_data),
        .de_imm      (de_imm),
        .de_rs1      (de_rs1),
        .de_rs2      (de_rs2),
        .de_rd       (de_rd)
    );

    execute_stage execute0 (
        .clk           (clk),
        .rst_n         (rst_n),
        .de_ctrl       (de_ctrl),
        .de_pc         (de_pc),
        .de_rs1_data   (de_rs1_data),
        .de_rs2_data   (de_rs2_data),
        .de_imm        (de_imm),
        .de_rs1        (de_rs1),
        .de_rs2        (de_rs2),
        .de_rd         (de_rd),
        .wb            (wb0),
        .hz            (hz0),
        .em_ctrl       (em_ctrl),
        .em_result     (em_result),
        .em_store_data (em_store_data),
        .em_rd         (em_rd)
    );

    memory_stage memory0 (
        .clk           (clk),
        .rst_n         (rst_n),
        .em_ctrl       (em_ctrl),
        .em_result     (em_result),
        .em_store_data (em_store_data),
        .em_rd         (em_rd),
        .mem_read_data (mem_read_data),
        .mem_request   (mem_request),
        .mem_write     (mem_write),
        .mem_addr      (mem_addr),
        .mem_data      (mem_data),
        .align_fault   (align_fault),
        .wb            (wb0)
    );

    // Retire port mirrors the writeback bus
    assign retire_valid = wb0.valid;
    assign retire_rd    = wb0.rd;
    assign retire_data  = wb0.data;

endmodule

//--- tb/core_checker.sv
`timescale 1ns/1ps

module core_checker import core_pkg::*; #(
    parameter int prog_len   = 200,
    parameter int dmem_words = 32
) (
    input  logic      clk,
    input  logic      rst_n,
    input  logic      test_done,
    input  word_t     pc_out,
    input  logic      mem_request,
    input  logic      mem_write,
    input  word_t     mem_addr,
    input  word_t     mem_data,
    input  logic      align_fault,
    input  logic      retire_valid,
    input  reg_addr_t retire_rd,
    input  word_t     retire_data,
    output int        tests_passed,
    output int        tests_failed
);

    // Filled from the testbench while the core sits in reset
    instr_t prog     [prog_len];
    word_t  init_mem [dmem_words];

    reg_addr_t exp_rd      [$];
    word_t     exp_data    [$];
    word_t     exp_ld_addr [$];
    word_t     exp_st_addr [$];
    word_t     exp_st_data [$];
    word_t     exp_fault   [$];
    int        errors;
    int        retires;
    int        stores;
    int        faults;
    int        test_id;

    initial begin
        tests_passed = 0;
        tests_failed = 0;
        errors       = 0;
        test_id      = 0;
    end

    task automatic report_mismatch(string name, word_t expected, word_t actual);
        $display("Mismatch at %0t ns: %s expected %h, got %h", $time, name, expected, actual);
        errors++;
    endtask

    // Instruction-level model of the whole program
    task automatic run_model();
        word_t  x   [32];
        word_t  mem [dmem_words];
        instr_t ins;
        word_t  a;
        word_t  b;
        word_t  imm_b;
        word_t  addr;
        word_t  res;
        logic   write;
        int     pc;
        int     next;
        int     idx;
        exp_rd.delete();
        exp_data.delete();
        exp_ld_addr.delete();
        exp_st_addr.delete();
        exp_st_data.delete();
        exp_fault.delete();
        retires = 0;
        stores  = 0;
        faults  = 0;
        foreach (x[i]) x[i] = '0;
        foreach (mem[i]) mem[i] = init_mem[i];
        pc = 0;
        while (pc < prog_len) begin
            ins   = prog[pc];
            a     = x[ins[19:15]];
            b     = x[ins[24:20]];
            imm_b = {{51{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
            addr  = a + ((ins[6:0] == op_store) ? {{52{ins[31]}}, ins[31:25], ins[11:7]}
                                                : {{52{ins[31]}}, ins[31:20]});
            idx   = int'(addr[10:3]) % dmem_words;
            res   = '0;
            write = 1'b0;
            next  = pc + 1;
            case (ins[6:0])
                op_reg: begin
                    write = 1'b1;
                    case ({ins[30], ins[14:12]})
                        4'b0000: res = a + b;
                        4'b1000: res = a - b;
                        4'b0001: res = a << b[5:0];
                        4'b0010: res = ($signed(a) < $signed(b)) ? 64'd1 : 64'd0;
                        4'b0011: res = (a < b) ? 64'd1 : 64'd0;
                        4'b0100: res = a ^ b;
                        4'b0101: res = a >> b[5:0];
                        4'b1101: res = $signed(a) >>> b[5:0];
                        4'b0110: res = a | b;
                        default: res = a & b;
                    endcase
                end
                op_imm: begin
                    write = 1'b1;
                    res   = addr;
                end
                op_load: begin
                    if (addr[2:0] != 3'b000) begin
                        exp_fault.push_back(addr);
                    end else begin
                        write = 1'b1;
                        res   = mem[idx];
                        exp_ld_addr.push_back(addr);
                    end
                end
                op_store: begin
                    if (addr[2:0] != 3'b000) begin
                        exp_fault.push_back(addr);
                    end else begin
                        mem[idx] = b;
                        exp_st_addr.push_back(addr);
                        exp_st_data.push_back(b);
                    end
                end
                op_branch: begin
                    if (a == b) begin
                        next = pc + int'($signed(imm_b) >>> 2);
                    end
                end
                default: ;
            endcase
            // x0 writes are dropped and never show up on the retire port
            if (write && (ins[11:7] != 5'd0)) begin
                x[ins[11:7]] = res;
                exp_rd.push_back(ins[11:7]);
                exp_data.push_back(res);
            end
            pc = next;
        end
    endtask

    always @(posedge rst_n) begin
        run_model();
    end

    always @(negedge clk) begin
        if (!rst_n) begin
            if ((pc_out !== '0) || (mem_request !== 1'b0) || (mem_write !== 1'b0) ||
                (align_fault !== 1'b0) || (retire_valid !== 1'b0)) begin
                $display("At %0t ns the core is not idle while held in reset", $time);
                errors++;
            end
        end
    end

    always @(posedge clk) begin
        if (rst_n) begin
            if (retire_valid) begin
                retires++;
                if (exp_rd.size() == 0) begin
                    $display("At %0t ns the core retired x%0d after the model had finished",
                             $time, retire_rd);
                    errors++;
                end else begin
                    if (retire_rd !== exp_rd[0]) begin
                        report_mismatch("retire_rd", word_t'(exp_rd[0]), word_t'(retire_rd));
                    end
                    if (retire_data !== exp_data[0]) begin
                        report_mismatch("retire_data", exp_data[0], retire_data);
                    end
                    void'(exp_rd.pop_front());
                    void'(exp_data.pop_front());
                end
            end
            if (mem_request && !mem_write) begin
                if (exp_ld_addr.size() == 0) begin
                    $display("At %0t ns the core loaded from %h but the model has no load left",
                             $time, mem_addr);
                    errors++;
                end else begin
                    if (mem_addr !== exp_ld_addr[0]) begin
                        report_mismatch("mem_addr", exp_ld_addr[0], mem_addr);
                    end
                    void'(exp_ld_addr.pop_front());
                end
            end
            if (mem_write && !mem_request) begin
                $display("At %0t ns the core wrote memory without a memory request", $time);
                errors++;
            end
            if (mem_write) begin
                stores++;
                if (exp_st_addr.size() == 0) begin
                    $display("At %0t ns the core stored to %h but the model has no store left",
                             $time, mem_addr);
                    errors++;
                end else begin
                    if (mem_addr !== exp_st_addr[0]) begin
                        report_mismatch("mem_addr", exp_st_addr[0], mem_addr);
                    end
                    if (mem_data !== exp_st_data[0]) begin
                        report_mismatch("mem_data", exp_st_data[0], mem_data);
                    end
                    void'(exp_st_addr.pop_front());
                    void'(exp_st_data.pop_front());
                end
            end
            if (align_fault) begin
                faults++;
                if (mem_request || mem_write) begin
                    $display("At %0t ns the core accessed memory during an alignment fault",
                             $time);
                    errors++;
                end
                if (exp_fault.size() == 0) begin
                    $display("At %0t ns the core raised an alignment fault the model does not expect",
                             $time);
                    errors++;
                end else begin
                    if (mem_addr !== exp_fault[0]) begin
                        report_mismatch("mem_addr", exp_fault[0], mem_addr);
                    end
                    void'(exp_fault.pop_front());
                end
            end
        end
    end

    // End of one program run
    always @(posedge test_done) begin
        if ((exp_rd.size() != 0) || (exp_ld_addr.size() != 0) || (exp_st_addr.size() != 0) ||
            (exp_fault.size() != 0)) begin
            $display("Test %0d: the core missed %0d retires, %0d loads, %0d stores and %0d faults",
                     test_id, exp_rd.size(), exp_ld_addr.size(), exp_st_addr.size(),
                     exp_fault.size());
            errors++;
        end
        if (errors == 0) begin
            tests_passed++;
            $display("Test %0d passed: %0d retires, %0d stores, %0d alignment faults",
                     test_id, retires, stores, faults);
        end else begin
            tests_failed++;
            $display("Test %0d failed with %0d errors", test_id, errors);
        end
        errors = 0;
        test_id++;
    end

endmodule

//--- tb/tb_rv_core.sv
`timescale 1ns/1ps

module tb_rv_core import core_pkg::*; ();

    localparam int     prog_len   = 200;
    localparam int     imem_words = 256;
    localparam int     dmem_words = 32;
    localparam int     num_tests  = 4;
    localparam int     max_cycles = 8 * prog_len + 50;
    localparam instr_t nop_instr  = 32'h0000_0013;

    logic        clk;
    logic        rst_n;
    logic        test_done;
    instr_t      instruction_in;
    word_t       mem_read_data;
    word_t       pc_out;
    word_t       mem_addr;
    word_t       mem_data;
    logic        mem_request;
    logic        mem_write;
    logic        align_fault;
    logic        retire_valid;
    reg_addr_t   retire_rd;
    word_t       retire_data;
    int          tests_passed;
    int          tests_failed;
    int          cycles;
    logic [31:0] rng;

    instr_t imem [imem_words];
    word_t  dmem [dmem_words];

    initial clk = 1'b0;
    always #20 clk = ~clk;

    // Both memories answer in the same cycle
    assign instruction_in = imem[pc_out[9:2]];
    assign mem_read_data  = dmem[mem_addr[7:3]];

    always @(posedge clk) begin
        if (mem_write) begin
            dmem[mem_addr[7:3]] <= mem_data;
        end
    end

    rv_core dut0 (
        .clk            (clk),
        .rst_n          (rst_n),
        .instruction_in (instruction_in),
        .mem_read_data  (mem_read_data),
        .pc_out         (pc_out),
        .mem_addr       (mem_addr),
        .mem_data       (mem_data),
        .mem_request    (mem_request),
        .mem_write      (mem_write),
        .align_fault    (align_fault),
        .retire_valid   (retire_valid),
        .retire_rd      (retire_rd),
        .retire_data    (retire_data)
    );

    core_checker #(
        .prog_len   (prog_len),
        .dmem_words (dmem_words)
    ) checker0 (
        .clk          (clk),
        .rst_n        (rst_n),
        .test_done    (test_done),
        .pc_out       (pc_out),
        .mem_request  (mem_request),
        .mem_write    (mem_write),
        .mem_addr     (mem_addr),
        .mem_data     (mem_data),
        .align_fault  (align_fault),
        .retire_valid (retire_valid),
        .retire_rd    (retire_rd),
        .retire_data  (retire_data),
        .tests_passed (tests_passed),
        .tests_failed (tests_failed)
    );

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] v;
        v = s ^ (s << 13);
        v = v ^ (v >> 17);
        v = v ^ (v << 5);
        return v;
    endfunction

    task automatic build_program(input int test_id);
        logic [31:0] r;
        logic [2:0]  f3;
        logic [6:0]  f7;
        logic [11:0] off;
        logic [4:0]  boff;
        reg_addr_t   rd;
        reg_addr_t   rs1;
        reg_addr_t   rs2;
        rng = 32'hd43d ^ (32'(test_id) << 20);
        foreach (imem[i]) imem[i] = nop_instr;
        // addi x1, x0, 64 sets up the load/store base
        imem[0] = {12'd64, 5'd0, 3'b000, 5'd1, op_imm};
        for (int i = 1; i < prog_len; i++) begin
            rng  = xorshift(rng);
            r    = rng;
            // x1 is never a target, x0 sometimes is
            rd   = (r[7:5] == 3'd1) ? 5'd0 : {2'b00, r[7:5]};
            rs1  = {2'b00, r[10:8]};
            rs2  = {2'b00, r[13:11]};
            f3   = r[20:18];
            f7   = (r[21] && ((f3 == 3'b000) || (f3 == 3'b101))) ? 7'h20 : 7'h00;
            off  = 12'(int'(r[29:26]) * 8 - 64 +
                       ((r[25:22] == 4'd0) ? int'(r[31:30]) + 1 : 0));
            boff = r[19] ? 5'd12 : 5'd8;
            case (r[17:14])
                4'd0, 4'd1, 4'd2, 4'd3, 4'd4, 4'd5: imem[i] = {f7, rs2, rs1, f3, rd, op_reg};
                4'd9, 4'd10:  imem[i] = {off, 5'd1, 3'b011, rd, op_load};
                4'd11, 4'd12: imem[i] = {off[11:5], rs2, 5'd1, 3'b011, off[4:0], op_store};
                4'd13: imem[i] = {7'd0, (r[18] ? rs1 : rs2), rs1, 3'b000, boff[4:1], 1'b0,
                                  op_branch};
                default: imem[i] = {r[31:20], rs1, 3'b000, rd, op_imm};
            endcase
            checker0.prog[i] = imem[i];
        end
        checker0.prog[0] = imem[0];
        for (int i = 0; i < dmem_words; i++) begin
            rng                  = xorshift(rng);
            dmem[i]              = {rng, 32'(i) * 32'h9e37_79b9};
            checker0.init_mem[i] = dmem[i];
        end
    endtask

    always @(posedge clk) begin
        if (!rst_n) begin
            cycles <= 0;
        end else if (cycles >= max_cycles) begin
            $display("Timeout: a program did not run to its end within %0d cycles", max_cycles);
            $display("Simulation failed");
            $finish;
        end else begin
            cycles <= cycles + 1;
        end
    end

    initial begin
        rst_n     = 1'b0;
        test_done = 1'b0;
        cycles    = 0;
        for (int t = 0; t < num_tests; t++) begin
            build_program(t);
            repeat (3) @(posedge clk);
            #2 rst_n = 1'b1;
            // Forward branches only, so the pc passing the end means the program drained
            while (pc_out < word_t'(4 * (prog_len + 8))) begin
                @(posedge clk);
                #2;
            end
            test_done = 1'b1;
            @(posedge clk);
            #2 test_done = 1'b0;
            rst_n = 1'b0;
        end
        @(posedge clk);
        #2;
        $display("Tests passed: %0d, failed: %0d", tests_passed, tests_failed);
        if ((tests_failed == 0) && (tests_passed == num_tests)) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule
